/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module main_board_tb \
    -o main_board_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/main_board_sim)
echo "$out"
echo "$out" | grep -qx "Testbench passed" && echo "PASS" || { echo "FAIL"; exit 1; }

/* source/cpu_bus_if.sv */
interface cpu_bus_if import main_map_pkg::*; ();

    // CPU address, page and offset views
    cpu_addr_u          addr;
    // CPU write data
    logic [data_w-1:0]  wdata;
    // Z80 strobes, all active low
    logic               mreq_n;
    logic               iorq_n;
    logic               wr_n;

    // Address decoder sees the whole bus
    modport decoder (
        input addr,
        input wdata,
        input mreq_n,
        input iorq_n,
        input wr_n
    );

    // Control registers only need data and the acknowledge strobe
    modport ctrl (
        input wdata,
        input iorq_n
    );

    // CPU side of the shared RAM
    modport ram (
        input addr,
        input wdata,
        input mreq_n,
        input wr_n
    );

endinterface

/* source/main_board.sv */
module main_board import main_map_pkg::*; import main_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                lvbl,

    // Main CPU bus
    input  logic [addr_w-1:0]   cpu_addr,
    input  logic [data_w-1:0]   cpu_wdata,
    input  logic                cpu_mreq_n,
    input  logic                cpu_iorq_n,
    input  logic                cpu_wr_n,
    output logic [data_w-1:0]   cpu_rdata,
    output logic                cpu_int_n,
    output logic                cpu_wait_n,

    // Video devices
    output logic                vram_cs,
    output logic                vctrl_cs,
    output logic                pal_cs,
    input  logic [data_w-1:0]   vram_dout,
    input  logic [data_w-1:0]   pal_dout,

    // Sound MCU
    output logic                snd_rstn,
    input  logic [ram_aw-1:0]   shr_addr,
    input  logic [data_w-1:0]   shr_din,
    input  logic                shr_we,
    output logic [data_w-1:0]   shr_dout,

    // ROM
    output logic [rom_aw-1:0]   rom_addr,
    output logic                rom_cs,
    input  logic                rom_ok,
    input  logic [data_w-1:0]   rom_data
);

    logic [bank_w-1:0] bank;
    logic              bank_wr;
    logic              ram_cs;
    logic [data_w-1:0] ram_rdata;

    cpu_bus_if bus_i ();

    // CPU pins onto the internal bus
    assign bus_i.addr   = cpu_addr;
    assign bus_i.wdata  = cpu_wdata;
    assign bus_i.mreq_n = cpu_mreq_n;
    assign bus_i.iorq_n = cpu_iorq_n;
    assign bus_i.wr_n   = cpu_wr_n;

    main_decoder main_decoder_i (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus_i),
        .bank       (bank),
        .ram_rdata  (ram_rdata),
        .vram_dout  (vram_dout),
        .pal_dout   (pal_dout),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .rom_cs     (rom_cs),
        .vram_cs    (vram_cs),
        .vctrl_cs   (vctrl_cs),
        .pal_cs     (pal_cs),
        .ram_cs     (ram_cs),
        .bank_wr    (bank_wr),
        .rom_addr   (rom_addr),
        .cpu_rdata  (cpu_rdata),
        .cpu_wait_n (cpu_wait_n)
    );

    main_ctrl_regs main_ctrl_regs_i (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus_i),
        .bank_wr    (bank_wr),
        .lvbl       (lvbl),
        .bank       (bank),
        .snd_rstn   (snd_rstn),
        .cpu_int_n  (cpu_int_n)
    );

    // Mailbox RAM between main CPU and sound MCU
    shared_ram shared_ram_i (
        .clk        (clk),
        .bus        (bus_i),
        .ram_cs     (ram_cs),
        .ram_rdata  (ram_rdata),
        .shr_addr   (shr_addr),
        .shr_din    (shr_din),
        .shr_we     (shr_we),
        .shr_dout   (shr_dout)
    );

endmodule

/* source/main_ctrl_pkg.sv */
package main_ctrl_pkg;

    // ROM bank register width
    localparam int bank_w = 3;

    // Banked window maps from 8 KB slot 4 upwards
    // i.e. bank 0 starts at ROM address 0x08000
    localparam logic [3:0] bank_base = 4'b0100;

    // Bank register layout
    // bits 2..0 select the ROM bank
    // bit 4 releases the sound CPU from reset
    localparam int snd_run_bit = 4;

    // Open bus value
    localparam logic [7:0] unmapped_data = 8'hFF;

endpackage

/* source/main_ctrl_regs.sv */
module main_ctrl_regs import main_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    cpu_bus_if.ctrl             bus,

    // Write strobe from the decoder
    input  logic                bank_wr,
    // Vertical blank is low during blanking
    input  logic                lvbl,

    output logic [bank_w-1:0]   bank,
    output logic                snd_rstn,
    output logic                cpu_int_n
);

    logic lvbl_l;
    logic lvbl_fall;
    logic int_ack;

    // Blank starts when lvbl drops
    assign lvbl_fall = lvbl_l && !lvbl;

    // Board acks on iorq_n alone without m1_n
    assign int_ack = !bus.iorq_n;

    // Bank and sound CPU reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank     <= '0;
            snd_rstn <= 1'b0;
        end else if (bank_wr) begin
            bank     <= bus.wdata[bank_w-1:0];
            snd_rstn <= bus.wdata[snd_run_bit];
        end
    end

    // Previous lvbl for edge detection
    // Starts low so blanking already under way at reset is no edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
        end
    end

    // Interrupt latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_int_n <= 1'b1;
        end else if (int_ack) begin
            // Ack beats a coincident edge
            cpu_int_n <= 1'b1;
        end else if (lvbl_fall) begin
            cpu_int_n <= 1'b0;
        end
    end

endmodule

/* source/main_decoder.sv */
module main_decoder import main_map_pkg::*; import main_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    cpu_bus_if.decoder          bus,

    // Bank from the control register
    input  logic [bank_w-1:0]   bank,

    // Device read data
    input  logic [data_w-1:0]   ram_rdata,
    input  logic [data_w-1:0]   vram_dout,
    input  logic [data_w-1:0]   pal_dout,
    input  logic [data_w-1:0]   rom_data,
    input  logic                rom_ok,

    // Registered selects
    output logic                rom_cs,
    output logic                vram_cs,
    output logic                vctrl_cs,
    output logic                pal_cs,
    output logic                ram_cs,
    output logic                bank_wr,

    output logic [rom_aw-1:0]   rom_addr,
    output logic [data_w-1:0]   cpu_rdata,
    output logic                cpu_wait_n
);

    logic mem_rq;
    logic cpu_wr;
    logic [7:0] page_hi;

    // Memory request qualifier
    assign mem_rq = !bus.mreq_n;
    assign cpu_wr = !bus.wr_n;

    // A15..A8 as one byte
    assign page_hi = {bus.addr.page.region, bus.addr.page.block};

    // Chip selects, one cycle behind the bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            vram_cs  <= 1'b0;
            vctrl_cs <= 1'b0;
            pal_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            bank_wr  <= 1'b0;
        end else begin
            // 0000 to BFFF, fixed ROM plus banked window
            rom_cs   <= mem_rq && (bus.addr.page.region < rom_top);
            // C000 to DFFF
            vram_cs  <= mem_rq && (bus.addr.ofs.window == vram_page);
            // E000 to EFFF
            ram_cs   <= mem_rq && (bus.addr.page.region == ram_page);
            // F000 to F3FF, internal RAM and config of the video chip
            vctrl_cs <= mem_rq && (bus.addr.page.region == ctrl_page)
                        && (bus.addr.page.block <= vctrl_max);
            // Bank register is write only
            bank_wr  <= mem_rq && cpu_wr && (page_hi == bank_reg_page);
            pal_cs   <= mem_rq && (page_hi == pal_page);
        end
    end

    // Banked ROM address
    always_comb begin
        // Below 8000 the address goes straight through
        rom_addr = {2'b00, bus.addr.ofs.window[1:0], bus.addr.ofs.offset};
        // 8000 to BFFF lands in the selected 8 KB slot
        if (bus.addr.ofs.window[2]) begin
            rom_addr[rom_aw-1:ram_aw] = bank_base + 4'(bank);
        end
    end

    // Read data mux, ROM has top priority
    always_ff @(posedge clk) begin
        if (rom_cs) begin
            cpu_rdata <= rom_data;
        end else if (ram_cs) begin
            cpu_rdata <= ram_rdata;
        end else if (vram_cs || vctrl_cs) begin
            // Video chip returns both RAM and control data
            cpu_rdata <= vram_dout;
        end else if (pal_cs) begin
            cpu_rdata <= pal_dout;
        end else begin
            cpu_rdata <= unmapped_data;
        end
    end

    // Stall the CPU until the ROM has the byte
    assign cpu_wait_n = !(rom_cs && !rom_ok);

endmodule

/* source/main_map_pkg.sv */
package main_map_pkg;

    // Bus widths
    localparam int addr_w = 16;
    localparam int ram_aw = 13;
    localparam int rom_aw = 17;
    localparam int data_w = 8;

    // First 4 KB page past the ROM space
    localparam logic [3:0] rom_top = 4'hC;

    // 8 KB video RAM window, C000 to DFFF
    localparam logic [2:0] vram_page = 3'b110;

    // Shared RAM with the sound MCU, E000 to EFFF
    localparam logic [3:0] ram_page = 4'hE;

    // Control and video-control page
    localparam logic [3:0] ctrl_page = 4'hF;

    // Video control covers blocks F0 to F3
    localparam logic [3:0] vctrl_max = 4'd3;

    // 256-byte pages inside the control page
    localparam logic [7:0] bank_reg_page = 8'hF6;
    localparam logic [7:0] pal_page      = 8'hF8;

    // Page view for the selects
    // region is A15..A12, block is A11..A8
    typedef struct packed {
        logic [3:0] region;
        logic [3:0] block;
        logic [7:0] low;
    } addr_page_t;

    // Offset view for 8 KB windows
    // window is A15..A13
    typedef struct packed {
        logic [addr_w-ram_aw-1:0] window;
        logic [ram_aw-1:0]        offset;
    } addr_ofs_t;

    // Same CPU address, decoded two ways
    typedef union packed {
        addr_page_t page;
        addr_ofs_t  ofs;
    } cpu_addr_u;

endpackage

/* source/shared_ram.sv */
module shared_ram import main_map_pkg::*; (
    input  logic                clk,
    cpu_bus_if.ram              bus,

    // Main CPU port
    input  logic                ram_cs,
    output logic [data_w-1:0]   ram_rdata,

    // Sound MCU port
    input  logic [ram_aw-1:0]   shr_addr,
    input  logic [data_w-1:0]   shr_din,
    input  logic                shr_we,
    output logic [data_w-1:0]   shr_dout
);

    logic [data_w-1:0] mem [0:(2**ram_aw)-1];
    logic              cpu_we;
    logic [ram_aw-1:0] cpu_a;

    // CPU sees the RAM through the low 13 address bits
    assign cpu_a  = bus.addr.ofs.offset;

    // Select is registered, strobes are live
    assign cpu_we = ram_cs && !bus.wr_n && !bus.mreq_n;

    // Both ports on the same clock
    // No arbitration, same-address writes collide
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_a] <= bus.wdata;
        end
        if (shr_we) begin
            mem[shr_addr] <= shr_din;
        end
        // Read before write on each port
        ram_rdata <= mem[cpu_a];
        shr_dout  <= mem[shr_addr];
    end

endmodule

/* verif/main_board_checker.sv */
module main_board_checker import main_map_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic [addr_w-1:0] cpu_addr,
    input logic              cpu_mreq_n,
    input logic              rom_ok,
    input logic              rom_cs,
    input logic              vram_cs,
    input logic              vctrl_cs,
    input logic              pal_cs,
    input logic              ram_cs,
    input logic              cpu_wait_n,
    input logic              cpu_int_n
);

    // Windows of the memory map never overlap
    one_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, vram_cs, vctrl_cs, pal_cs, ram_cs}))
        else $error("more than one chip select high");

    // A stall needs a ROM access on the bus and a ROM that is not ready
    wait_from_rom: assert property (@(posedge clk) disable iff (rst)
        !cpu_wait_n |-> !rom_ok && $past(!cpu_mreq_n && (cpu_addr < 16'hC000)))
        else $error("cpu_wait_n low outside a stalled ROM access");

    // Interrupt stays idle while in reset
    int_in_reset: assert property (@(posedge clk)
        rst |-> cpu_int_n)
        else $error("cpu_int_n low during reset");

endmodule

// ram_cs is internal to the board
bind main_board main_board_checker main_board_checker_i (
    .clk        (clk),
    .rst        (rst),
    .cpu_addr   (cpu_addr),
    .cpu_mreq_n (cpu_mreq_n),
    .rom_ok     (rom_ok),
    .rom_cs     (rom_cs),
    .vram_cs    (vram_cs),
    .vctrl_cs   (vctrl_cs),
    .pal_cs     (pal_cs),
    .ram_cs     (ram_cs),
    .cpu_wait_n (cpu_wait_n),
    .cpu_int_n  (cpu_int_n)
);

/* verif/main_board_tb.sv */
module main_board_tb import main_map_pkg::*; ();

    // 25 bus accesses of at most 8 cycles each and a wide margin on top
    localparam int max_cycles = 2000;

    logic clk, rst, lvbl;
    logic [addr_w-1:0] cpu_addr;
    logic [data_w-1:0] cpu_wdata, cpu_rdata;
    logic cpu_mreq_n, cpu_iorq_n, cpu_wr_n, cpu_int_n, cpu_wait_n;
    logic vram_cs, vctrl_cs, pal_cs;
    logic [data_w-1:0] vram_dout, pal_dout;
    logic snd_rstn, shr_we;
    logic [ram_aw-1:0] shr_addr;
    logic [data_w-1:0] shr_din, shr_dout;
    logic [rom_aw-1:0] rom_addr;
    logic rom_cs, rom_ok;
    logic [data_w-1:0] rom_data;

    integer seed = 32'h75619a3e;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;
    int test_errors;
    string test_name;

    // Snapshot taken in the data phase of the last access
    logic [rom_aw-1:0] last_rom_addr;
    logic [data_w-1:0] last_rdata;
    // rom_cs, vram_cs, vctrl_cs, pal_cs
    logic [3:0] last_sel;
    int last_waits;

    main_board main_board_i (.*);

    always #4 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_byte(input string what, input logic [data_w-1:0] exp,
                              input logic [data_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, got %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_rom_addr(input string what, input logic [rom_aw-1:0] exp,
                                  input logic [rom_aw-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, got %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %b, got %b", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    // One CPU cycle with the bus held while the ROM stalls
    task automatic cpu_access(input logic [addr_w-1:0] addr, input logic wr,
                              input logic [data_w-1:0] wdata, input int rom_delay);
        @(negedge clk);
        cpu_addr = addr;
        cpu_wdata = wdata;
        cpu_wr_n = !wr;
        cpu_mreq_n = 1'b0;
        // Slow ROM holds rom_ok low for rom_delay cycles
        rom_ok = (rom_delay == 0);
        // Selects register on the first edge and read data on the second
        repeat (2) @(posedge clk);
        @(negedge clk);
        last_waits = 0;
        while (!cpu_wait_n) begin
            last_waits++;
            if (last_waits >= rom_delay) begin
                rom_ok = 1'b1;
            end
            @(negedge clk);
        end
        // Third cycle of the access
        @(posedge clk);
        @(negedge clk);
        last_rom_addr = rom_addr;
        last_rdata = cpu_rdata;
        last_sel = {rom_cs, vram_cs, vctrl_cs, pal_cs};
        // Bank register samples wdata once more after the release
        cpu_mreq_n = 1'b1;
        cpu_wr_n = 1'b1;
    endtask

    task automatic cpu_read(input logic [addr_w-1:0] addr, input int rom_delay,
                            output logic [data_w-1:0] data);
        cpu_access(addr, 1'b0, cpu_wdata, rom_delay);
        data = last_rdata;
    endtask

    task automatic cpu_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        cpu_access(addr, 1'b1, data, 0);
    endtask

    task automatic rom_reads();
        logic [31:0] rnd;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        start_test("rom_read");
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            addr = {1'b0, rnd[14:0]};
            rom_data = rnd[23:16];
            // Last one is a slow ROM
            cpu_read(addr, (i == 3) ? 4 : 0, data);
            check_rom_addr("rom_addr", {1'b0, addr}, last_rom_addr);
            check_byte("rdata", rnd[23:16], data);
            check_bit("rom_cs", 1'b1, last_sel[3]);
        end
        check_bit("wait until rom_ok", 1'b1, last_waits == 4);
        end_test();
    endtask

    task automatic bank_switch();
        logic [31:0] rnd;
        logic [data_w-1:0] d;
        logic [data_w-1:0] data;
        logic [ram_aw-1:0] off;
        logic [3:0] slot;
        start_test("bank");
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            d = rnd[7:0];
            // Sound reset both ways
            d[4] = i[0];
            off = rnd[20:8];
            cpu_write(16'hF600, d);
            check_bit("snd_rstn", d[4], snd_rstn);
            // Bank n sits in 8 KB slot 4 + n
            slot = 4'd4 + {1'b0, d[2:0]};
            rom_data = rnd[31:24];
            cpu_read({3'b101, off}, 0, data);
            check_rom_addr("rom_addr", {slot, off}, last_rom_addr);
            check_byte("rdata", rnd[31:24], data);
        end
        end_test();
    endtask

    task automatic shared_ram_rw();
        logic [31:0] rnd;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        start_test("shared_ram");
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            // Even address for the CPU and the next odd one for the MCU
            addr = {4'hE, rnd[11:1], 1'b0};
            cpu_write(addr, rnd[19:12]);
            shr_addr = addr[ram_aw-1:0];
            @(negedge clk);
            check_byte("shr_dout", rnd[19:12], shr_dout);
            shr_addr = {addr[ram_aw-1:1], 1'b1};
            shr_din = rnd[27:20];
            shr_we = 1'b1;
            @(negedge clk);
            shr_we = 1'b0;
            cpu_read({addr[addr_w-1:1], 1'b1}, 0, data);
            check_byte("cpu_rdata", rnd[27:20], data);
        end
        end_test();
    endtask

    task automatic device_selects();
        logic [31:0] rnd;
        logic [data_w-1:0] data;
        start_test("selects");
        rnd = $random(seed);
        vram_dout = rnd[7:0];
        pal_dout = rnd[15:8];
        cpu_read(16'hC000, 0, data);
        check_bit("vram_cs C000", 1'b1, last_sel[2]);
        check_byte("C000", rnd[7:0], data);
        cpu_read(16'hD800, 0, data);
        check_bit("vram_cs D800", 1'b1, last_sel[2]);
        check_byte("D800", rnd[7:0], data);
        // Video control reads come back on the VRAM bus
        cpu_read(16'hF300, 0, data);
        check_bit("vctrl_cs F300", 1'b1, last_sel[1]);
        check_byte("F300", rnd[7:0], data);
        cpu_read(16'hF800, 0, data);
        check_bit("pal_cs F800", 1'b1, last_sel[0]);
        check_byte("F800", rnd[15:8], data);
        // Hole in the control page
        cpu_read(16'hF400, 0, data);
        check_bit("no select F400", 1'b0, |last_sel);
        check_byte("F400", 8'hFF, data);
        end_test();
    endtask

    task automatic vblank_irq();
        start_test("vblank_irq");
        @(negedge clk);
        check_bit("idle", 1'b1, cpu_int_n);
        lvbl = 1'b0;
        @(negedge clk);
        check_bit("after fall", 1'b0, cpu_int_n);
        // Latched so the end of blank leaves it set
        lvbl = 1'b1;
        repeat (3) @(negedge clk);
        check_bit("lvbl high", 1'b0, cpu_int_n);
        cpu_iorq_n = 1'b0;
        @(negedge clk);
        cpu_iorq_n = 1'b1;
        check_bit("after ack", 1'b1, cpu_int_n);
        end_test();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        lvbl = 1'b1;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_mreq_n = 1'b1;
        cpu_iorq_n = 1'b1;
        cpu_wr_n = 1'b1;
        vram_dout = '0;
        pal_dout = '0;
        shr_addr = '0;
        shr_din = '0;
        shr_we = 1'b0;
        rom_ok = 1'b1;
        rom_data = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        rom_reads();
        bank_switch();
        shared_ram_rw();
        device_selects();
        vblank_irq();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/main_map_pkg.sv
source/main_ctrl_pkg.sv
source/cpu_bus_if.sv
source/main_decoder.sv
source/main_ctrl_regs.sv
source/shared_ram.sv
source/main_board.sv
verif/main_board_checker.sv
verif/main_board_tb.sv
